//--- Bender.yml
package:
  name: fetch_front_end

sources:
  - files:
      - common/fetchPkg.sv
      - common/predictIf.sv
      - icache/instrRom.sv
      - icache/icache.sv
      - src/branchPredictor.sv
      - fetch/pcUpdate.sv
      - src/fetchTop.sv
  - target: simulation
    files:
      - testbench/fetchTb.sv

//--- common/fetchPkg.sv
package fetchPkg;

    //////////////////////////////////////////////////////////////////////
    // Datapath and memory geometry
    //////////////////////////////////////////////////////////////////////

    // Word and address width
    localparam int XLen        = 32;

    // Instruction ROM, one word per entry
    localparam int RomWords    = 256;
    localparam int RomAddrBits = $clog2(RomWords);

    // Direct-mapped cache, one word per line
    localparam int CacheLines  = 16;
    localparam int IndexBits   = $clog2(CacheLines);
    // Everything above index and byte offset
    localparam int TagBits     = XLen - IndexBits - 2;

    // Refill wait before the line write
    localparam int FillLatency = 2;
    localparam int FillCntBits = $clog2(FillLatency + 1);

    //////////////////////////////////////////////////////////////////////
    // Instruction encoding
    //////////////////////////////////////////////////////////////////////

    // Direct jump, MIPS J format
    localparam logic [5:0] OpJump = 6'b000010;

    typedef logic [XLen-1:0] addrT;

    // Register format fields
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFieldsT;

    // Jump format, target is a word index
    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } jFieldsT;

    // Same 32 bits, two decodings
    typedef union packed {
        rFieldsT rView;
        jFieldsT jView;
    } instrWordT;

endpackage

//--- common/predictIf.sv
interface predictIf (
    input logic Clk
);
    import fetchPkg::*;

    // Fetch side
    addrT      fetchAddr;
    instrWordT instr;

    // Prediction, valid in the same cycle
    addrT      target;
    logic      taken;

    modport fetchSide (
        output fetchAddr,
        output instr,
        input  target,
        input  taken
    );

    // Clock only for checks in the predictor
    modport predictorSide (
        input  Clk,
        input  fetchAddr,
        input  instr,
        output target,
        output taken
    );

endinterface

//--- fetch/pcUpdate.sv
module pcUpdate (
    input  logic                Clk,
    input  logic                rstN,
    input  logic                flushPipeAndPc,
    input  fetchPkg::addrT      jmpAddr,
    input  logic                pcStall,
    input  logic                ifIdStall,
    input  logic                ifIdFlush,
    input  fetchPkg::instrWordT cacheData,
    input  logic                cacheMiss,
    output fetchPkg::addrT      cacheAddr,
    output fetchPkg::addrT      pc,
    output fetchPkg::addrT      instrAddr,
    output fetchPkg::instrWordT ir,
    output logic                irValid,
    predictIf.fetchSide         pred
);
    import fetchPkg::*;

    addrT fetchAddr;
    addrT seqAddr;
    addrT nextFetchAddr;
    logic holdAddr;
    logic loadBubble;
    logic loadWord;

    //////////////////////////////////////////////////////////////////////
    // Fetch address
    //////////////////////////////////////////////////////////////////////

    // Cache and predictor both see the current address
    assign cacheAddr      = fetchAddr;
    assign pred.fetchAddr = fetchAddr;
    assign pred.instr     = cacheData;

    assign seqAddr  = fetchAddr + addrT'(4);
    // Miss holds too, the word is not there yet
    assign holdAddr = pcStall || ifIdStall || cacheMiss;

    // Flush beats stall, stall beats prediction
    always_comb
    begin
        if (flushPipeAndPc)
            nextFetchAddr = jmpAddr;
        else if (holdAddr)
            nextFetchAddr = fetchAddr;
        else if (pred.taken)
            nextFetchAddr = pred.target;
        else
            nextFetchAddr = seqAddr;
    end

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
            fetchAddr <= '0;
        else
            fetchAddr <= nextFetchAddr;
    end

    //////////////////////////////////////////////////////////////////////
    // Fetch register
    //////////////////////////////////////////////////////////////////////

    // Bubble on a redirect, on a local flush, or while missing
    // ifIdStall freezes everything except a redirect
    assign loadBubble = flushPipeAndPc || (!ifIdStall && (ifIdFlush || cacheMiss));
    assign loadWord   = !flushPipeAndPc && !ifIdStall && !ifIdFlush && !cacheMiss;

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
            irValid <= 1'b0;
        else if (loadBubble)
            irValid <= 1'b0;
        else if (loadWord)
            irValid <= 1'b1;
    end

    // Address fields kept on a bubble, only ir is cleared
    always_ff @(posedge Clk)
    begin
        if (loadBubble)
        begin
            ir <= '0;
        end
        else if (loadWord)
        begin
            ir        <= cacheData;
            instrAddr <= fetchAddr;
            // Sequential PC for decode
            pc        <= seqAddr;
        end
    end

    // Fetch never leaves word alignment
    assert property (@(posedge Clk) disable iff (!rstN)
        fetchAddr[1:0] == 2'b00);

    // Redirect always drops the word in flight
    assert property (@(posedge Clk) disable iff (!rstN)
        flushPipeAndPc |=> !irValid);

endmodule

//--- filelist.f
common/fetchPkg.sv
common/predictIf.sv
icache/instrRom.sv
icache/icache.sv
src/branchPredictor.sv
fetch/pcUpdate.sv
src/fetchTop.sv
testbench/fetchTb.sv

//--- icache/icache.sv
module icache (
    input  logic                             Clk,
    input  logic                             rstN,
    input  fetchPkg::addrT                   addr,
    input  logic                             invalidate,
    input  fetchPkg::instrWordT              romData,
    input  logic                             abort,
    output fetchPkg::instrWordT              data,
    output logic                             miss,
    output logic [fetchPkg::RomAddrBits-1:0] romIndex
);
    import fetchPkg::*;

    // Line storage
    logic [TagBits-1:0]    tagArr [CacheLines];
    instrWordT             dataArr [CacheLines];
    logic [CacheLines-1:0] lineValid;

    // Address split
    logic [IndexBits-1:0]  index;
    logic [TagBits-1:0]    tag;

    // Refill sequencer
    logic [FillCntBits-1:0] fillCnt;
    logic                   fillWrite;

    //////////////////////////////////////////////////////////////////////
    // Lookup
    //////////////////////////////////////////////////////////////////////

    assign index    = addr[IndexBits+1:2];
    assign tag      = addr[XLen-1:IndexBits+2];
    // ROM is word indexed, byte offset dropped
    assign romIndex = addr[RomAddrBits+1:2];

    // Data only meaningful when miss is low
    assign data = dataArr[index];
    assign miss = !lineValid[index] || (tagArr[index] != tag);

    //////////////////////////////////////////////////////////////////////
    // Refill
    //////////////////////////////////////////////////////////////////////

    // Line written once the wait has run out
    assign fillWrite = miss && (fillCnt == FillCntBits'(FillLatency))
                       && !abort && !invalidate;

    // Counts miss cycles, restarts on hit, write, abort or invalidate
    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
            fillCnt <= '0;
        else if (abort || invalidate || !miss || fillWrite)
            fillCnt <= '0;
        else
            fillCnt <= fillCnt + 1'b1;
    end

    // Program write empties the whole cache
    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
            lineValid <= '0;
        else if (invalidate)
            lineValid <= '0;
        else if (fillWrite)
            lineValid[index] <= 1'b1;
    end

    always_ff @(posedge Clk)
    begin
        if (fillWrite)
        begin
            tagArr[index]  <= tag;
            dataArr[index] <= romData;
        end
    end

    // No line written in a program write cycle
    assert property (@(posedge Clk) disable iff (!rstN)
        invalidate |-> !fillWrite);

endmodule

//--- icache/instrRom.sv
module instrRom (
    input  logic                             Clk,
    input  logic                             we,
    input  logic [fetchPkg::RomAddrBits-1:0] writeIndex,
    input  fetchPkg::instrWordT              writeData,
    input  logic [fetchPkg::RomAddrBits-1:0] readIndex,
    output fetchPkg::instrWordT              readData
);
    import fetchPkg::*;

    //////////////////////////////////////////////////////////////////////
    // Program store
    //////////////////////////////////////////////////////////////////////

    // Undefined until the program port fills it
    instrWordT mem [RomWords];

    // Program port, one word per edge
    always_ff @(posedge Clk)
    begin
        if (we)
            mem[writeIndex] <= writeData;
    end

    // Refill path reads in the same cycle
    assign readData = mem[readIndex];

endmodule

//--- src/branchPredictor.sv
module branchPredictor (
    predictIf.predictorSide pred
);
    import fetchPkg::*;

    // Predecoded jump fields
    logic        isJump;
    logic [25:0] wordTarget;

    //////////////////////////////////////////////////////////////////////
    // Static prediction
    //////////////////////////////////////////////////////////////////////

    // Only the J format matters here
    assign isJump     = (pred.instr.jView.opcode == OpJump);
    assign wordTarget = pred.instr.jView.target;

    // Every direct jump taken
    assign pred.taken = isJump;

    // Region bits from fetch address, target in words
    assign pred.target = {pred.fetchAddr[XLen-1:XLen-4], wordTarget, 2'b00};

    // Predicted jump stays word aligned
    assert property (@(posedge pred.Clk)
        pred.taken |-> (pred.target[1:0] == 2'b00));

endmodule

//--- src/fetchTop.sv
module fetchTop (
    input  logic                             Clk,
    input  logic                             rstN,
    input  logic                             flushPipeAndPc,
    input  fetchPkg::addrT                   jmpAddr,
    input  logic                             pcStall,
    input  logic                             ifIdStall,
    input  logic                             ifIdFlush,
    input  logic                             progWe,
    input  logic [fetchPkg::RomAddrBits-1:0] progAddr,
    input  fetchPkg::instrWordT              progData,
    output fetchPkg::addrT                   pc,
    output fetchPkg::addrT                   instrAddr,
    output fetchPkg::instrWordT              ir,
    output logic                             irValid,
    output logic                             imiss
);
    import fetchPkg::*;

    // Fetch stage to cache
    addrT                   cacheAddr;
    instrWordT              cacheData;
    logic                   cacheMiss;

    // Cache to ROM
    logic [RomAddrBits-1:0] romIndex;
    instrWordT              romData;

    // Predictor link
    predictIf predLink (.Clk(Clk));

    assign imiss = cacheMiss;

    //////////////////////////////////////////////////////////////////////
    // Fetch stage
    //////////////////////////////////////////////////////////////////////

    pcUpdate fetchStage (
        .Clk            (Clk),
        .rstN           (rstN),
        .flushPipeAndPc (flushPipeAndPc),
        .jmpAddr        (jmpAddr),
        .pcStall        (pcStall),
        .ifIdStall      (ifIdStall),
        .ifIdFlush      (ifIdFlush),
        .cacheData      (cacheData),
        .cacheMiss      (cacheMiss),
        .cacheAddr      (cacheAddr),
        .pc             (pc),
        .instrAddr      (instrAddr),
        .ir             (ir),
        .irValid        (irValid),
        .pred           (predLink.fetchSide)
    );

    branchPredictor predictor (
        .pred (predLink.predictorSide)
    );

    //////////////////////////////////////////////////////////////////////
    // Memory side
    //////////////////////////////////////////////////////////////////////

    // Redirect abandons any refill in progress
    icache cache (
        .Clk        (Clk),
        .rstN       (rstN),
        .addr       (cacheAddr),
        .invalidate (progWe),
        .romData    (romData),
        .abort      (flushPipeAndPc),
        .data       (cacheData),
        .miss       (cacheMiss),
        .romIndex   (romIndex)
    );

    instrRom rom (
        .Clk        (Clk),
        .we         (progWe),
        .writeIndex (progAddr),
        .writeData  (progData),
        .readIndex  (romIndex),
        .readData   (romData)
    );

endmodule

//--- testbench/fetchTb.sv
module fetchTb;
    timeunit 1ns;
    timeprecision 1ps;

    import fetchPkg::*;

    localparam int ClkPeriod    = 100;
    localparam int WaitLimit    = 300;
    // Rough cycle budget per test phase
    localparam int LoadCycles   = RomWords + 8;
    localparam int LoopCycles   = 3 * (CacheLines * (FillLatency + 2) + 20);
    localparam int FlushCycles  = 2 * 40;
    localparam int StallCycles  = 12 * 12;
    localparam int RegFlushCycles = 4 * 12;
    localparam int TestCycles   = LoadCycles + LoopCycles + FlushCycles + StallCycles
                                  + RegFlushCycles + 20;
    localparam int MarginCycles = 500;

    // DUT inputs
    logic                   Clk;
    logic                   rstN;
    logic                   flushPipeAndPc;
    addrT                   jmpAddr;
    logic                   pcStall;
    logic                   ifIdStall;
    logic                   ifIdFlush;
    logic                   progWe;
    logic [RomAddrBits-1:0] progAddr;
    instrWordT              progData;

    // DUT outputs
    addrT                   pc;
    addrT                   instrAddr;
    instrWordT              ir;
    logic                   irValid;
    logic                   imiss;

    // Program mirror and expected fetch state
    instrWordT              model [RomWords];
    addrT                   expFetch;
    addrT                   expInstrAddr;
    instrWordT              expIr;
    logic                   expValid;
    logic                   hold;
    instrWordT              fetchedWord;

    // Cache model, one word per line
    logic [CacheLines-1:0]  cacheValid;
    addrT                   cacheLineAddr [CacheLines];
    int                     missCycles;
    int                     lineIdx;
    logic                   expMiss;

    string                  testName;
    int                     checkedWords;
    int                     missCount;
    instrWordT              word;
    addrT                   target;
    addrT                   got;
    int                     len;

    fetchTop UUT (
        .Clk            (Clk),
        .rstN           (rstN),
        .flushPipeAndPc (flushPipeAndPc),
        .jmpAddr        (jmpAddr),
        .pcStall        (pcStall),
        .ifIdStall      (ifIdStall),
        .ifIdFlush      (ifIdFlush),
        .progWe         (progWe),
        .progAddr       (progAddr),
        .progData       (progData),
        .pc             (pc),
        .instrAddr      (instrAddr),
        .ir             (ir),
        .irValid        (irValid),
        .imiss          (imiss)
    );

    initial
    begin
        Clk = 1'b0;
        forever #(ClkPeriod / 2) Clk = ~Clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model and checks
    //////////////////////////////////////////////////////////////////////

    // Flush, then hold, then predicted jump, then sequential
    function automatic addrT refNextAddr(addrT prev, logic flush, addrT jAddr, logic holdIt,
                                         instrWordT w);
        if (flush)
            return jAddr;
        if (holdIt)
            return prev;
        // Region bits kept, word target scaled to bytes
        if (w.jView.opcode == OpJump)
            return (prev & 32'hF000_0000) | (addrT'(w.jView.target) << 2);
        return prev + 4;
    endfunction

    // Random word that is never a jump
    function automatic instrWordT randomWord();
        instrWordT w;
        w = $urandom;
        if (w.jView.opcode == OpJump)
            w.jView.opcode = 6'h00;
        return w;
    endfunction

    function automatic instrWordT makeJump(addrT dest);
        instrWordT w;
        w.jView.opcode = OpJump;
        w.jView.target = dest[27:2];
        return w;
    endfunction

    task automatic checkAddr(string name, addrT expected, addrT actual);
        if (expected !== actual)
        begin
            $display("Mismatch %s expected %h actual %h", name, expected, actual);
            $display("test failed");
            $fatal(1);
        end
    endtask

    // Fields shown through the register view
    task automatic checkWord(string name, instrWordT expected, instrWordT actual);
        if (expected !== actual)
        begin
            $display("Mismatch %s expected %h (op %0d funct %0d) actual %h (op %0d funct %0d)",
                     name, expected, expected.rView.opcode, expected.rView.funct,
                     actual, actual.rView.opcode, actual.rView.funct);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic checkFlag(string name, logic expected, logic actual);
        if (expected !== actual)
        begin
            $display("Mismatch %s expected %b actual %b", name, expected, actual);
            $display("test failed");
            $fatal(1);
        end
    endtask

    // Outputs checked against last edge's prediction, then model steps
    always @(posedge Clk)
    begin
        if (!rstN)
        begin
            expFetch   = '0;
            expValid   = 1'b0;
            cacheValid = '0;
            missCycles = 0;
        end
        else
        begin
            // Miss from the modelled lines at the expected address
            lineIdx = expFetch[IndexBits+1:2];
            expMiss = !cacheValid[lineIdx] || (cacheLineAddr[lineIdx] !== expFetch);
            checkFlag({testName, " imiss"}, expMiss, imiss);
            checkFlag({testName, " irValid"}, expValid, irValid);
            if (expValid)
            begin
                checkAddr({testName, " instrAddr"}, expInstrAddr, instrAddr);
                checkAddr({testName, " pc"}, expInstrAddr + 4, pc);
                checkWord({testName, " ir"}, expIr, ir);
                checkedWords++;
            end
            // Miss acts as one more hold source
            hold        = pcStall || ifIdStall || expMiss;
            fetchedWord = model[expFetch[RomAddrBits+1:2]];
            if (flushPipeAndPc)
                expValid = 1'b0;
            else if (!ifIdStall && (ifIdFlush || expMiss))
                expValid = 1'b0;
            else if (!ifIdStall)
            begin
                expValid     = 1'b1;
                expInstrAddr = expFetch;
                expIr        = fetchedWord;
            end
            // Line filled after FillLatency waiting cycles
            // Flush or program write drops the refill
            if (progWe)
            begin
                cacheValid = '0;
                missCycles = 0;
            end
            else if (flushPipeAndPc || !expMiss)
                missCycles = 0;
            else if (missCycles == FillLatency)
            begin
                cacheValid[lineIdx]    = 1'b1;
                cacheLineAddr[lineIdx] = expFetch;
                missCycles             = 0;
            end
            else
                missCycles++;
            expFetch = refNextAddr(expFetch, flushPipeAndPc, jmpAddr, hold, fetchedWord);
        end
    end

    // Miss cycles, sampled mid-cycle
    always @(negedge Clk)
    begin
        if (rstN && imiss)
            missCount++;
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////////////

    task automatic loadProgramWord(int idx, instrWordT w);
        @(negedge Clk);
        progWe   = 1'b1;
        progAddr = idx[RomAddrBits-1:0];
        progData = w;
        model[idx] = w;
    endtask

    task automatic nextValidAddr(output addrT a);
        int cycles;
        cycles = 0;
        do
        begin
            @(posedge Clk);
            cycles++;
            if (cycles > WaitLimit)
            begin
                $display("Timed out waiting for a valid instruction in %s", testName);
                $display("test failed");
                $fatal(1);
            end
        end
        while (!irValid);
        a = instrAddr;
    endtask

    task automatic waitValidAddr(addrT a);
        addrT seen;
        int   count;
        count = 0;
        do
        begin
            nextValidAddr(seen);
            count++;
            if (count > WaitLimit)
            begin
                $display("Address %h never fetched in %s", a, testName);
                $display("test failed");
                $fatal(1);
            end
        end
        while (seen !== a);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        void'($urandom(15));
        rstN           = 1'b0;
        flushPipeAndPc = 1'b0;
        jmpAddr        = '0;
        // Fetch frozen until the program is in
        pcStall        = 1'b1;
        ifIdStall      = 1'b1;
        ifIdFlush      = 1'b0;
        progWe         = 1'b0;
        progAddr       = '0;
        progData       = '0;
        checkedWords   = 0;
        missCount      = 0;
        testName       = "reset";
        repeat (3) @(negedge Clk);
        rstN = 1'b1;

        // Loop over words 0..15, second jump from word 40 to word 64
        for (int i = 0; i < RomWords; i++)
        begin
            if (i == 15)
                word = makeJump(32'd0);
            else if (i == 40)
                word = makeJump(32'd256);
            else
                word = randomWord();
            loadProgramWord(i, word);
        end
        @(negedge Clk);
        progWe    = 1'b0;
        pcStall   = 1'b0;
        ifIdStall = 1'b0;

        // First pass refills every line
        testName  = "sequential";
        missCount = 0;
        waitValidAddr(32'd60);
        checkFlag("refill first pass miss", 1'b1, missCount != 0);

        testName = "jump";
        nextValidAddr(got);
        checkAddr("jump target", 32'd0, got);

        // Second pass all hits
        testName  = "refill second pass";
        missCount = 0;
        waitValidAddr(32'd60);
        checkFlag("refill second pass miss", 1'b0, missCount != 0);

        // Rewrite word 5 while frozen
        @(negedge Clk);
        pcStall   = 1'b1;
        ifIdStall = 1'b1;
        loadProgramWord(5, randomWord());
        @(negedge Clk);
        progWe    = 1'b0;
        pcStall   = 1'b0;
        ifIdStall = 1'b0;
        testName  = "rom rewrite";
        waitValidAddr(32'd20);

        // Redirect, one bubble then the target
        testName = "flush";
        target   = $urandom & 32'h3FC;
        @(negedge Clk);
        flushPipeAndPc = 1'b1;
        jmpAddr        = target;
        @(negedge Clk);
        flushPipeAndPc = 1'b0;
        nextValidAddr(got);
        checkAddr("flush target", target, got);

        // High tag forces a miss, second redirect lands mid-refill
        testName = "flush during miss";
        @(negedge Clk);
        flushPipeAndPc = 1'b1;
        jmpAddr        = 32'h0001_0000 | ($urandom & 32'h3FC);
        @(negedge Clk);
        checkFlag("flush during miss imiss", 1'b1, imiss);
        target  = $urandom & 32'h3FC;
        jmpAddr = target;
        @(negedge Clk);
        flushPipeAndPc = 1'b0;
        nextValidAddr(got);
        checkAddr("flush during miss target", target, got);

        // Random stall bursts on either stall input
        testName = "stalls";
        repeat (12)
        begin
            len = 1 + $urandom % 6;
            @(negedge Clk);
            if ($urandom % 2)
                pcStall = 1'b1;
            else
                ifIdStall = 1'b1;
            repeat (len) @(negedge Clk);
            pcStall   = 1'b0;
            ifIdStall = 1'b0;
            repeat (1 + $urandom % 4) @(negedge Clk);
        end

        // Drop single words from the fetch register
        testName = "fetch register flush";
        repeat (4)
        begin
            @(negedge Clk);
            while (imiss)
                @(negedge Clk);
            ifIdFlush = 1'b1;
            @(negedge Clk);
            ifIdFlush = 1'b0;
            repeat (6) @(negedge Clk);
        end

        repeat (20) @(negedge Clk);
        if (checkedWords > 60)
        begin
            $display("test passed");
            $finish;
        end
        else
        begin
            $display("Only %0d valid instructions were checked", checkedWords);
            $display("test failed");
            $fatal(1);
        end
    end

    // Run limit from the phase budgets
    initial
    begin
        #((TestCycles + MarginCycles) * ClkPeriod);
        $display("Watchdog expired before the tests finished");
        $display("test failed");
        $fatal(1);
    end

endmodule
